/* common/mci_pkg.sv */
// MCI shared definitions covering memory map, request and response structs, register offsets
package mci_pkg;

    //////////////////////////////////////////////////
    // Bus widths
    //////////////////////////////////////////////////
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;
    localparam int USER_WIDTH = 32;

    //////////////////////////////////////////////////
    // Memory map
    //////////////////////////////////////////////////
    localparam int KB = 1024;

    // Register window, 256 bytes at the bottom
    localparam int MCI_REG_MIN_ADDR_WIDTH = 8;
    localparam int MCI_REG_SIZE_BYTES     = 2 ** MCI_REG_MIN_ADDR_WIDTH;
    localparam logic [ADDR_WIDTH-1:0] MCI_REG_START_ADDR = 32'h0000_0000;
    localparam logic [ADDR_WIDTH-1:0] MCI_REG_END_ADDR   =
        MCI_REG_START_ADDR + MCI_REG_SIZE_BYTES - 1;

    // Mailboxes, 1 KB each
    localparam int MBOX_CSR_ADDR_WIDTH = 10;
    localparam int MBOX_SIZE_BYTES     = 2 ** MBOX_CSR_ADDR_WIDTH;
    localparam logic [ADDR_WIDTH-1:0] MBOX0_START_ADDR = 32'h0008_0000;
    localparam logic [ADDR_WIDTH-1:0] MBOX0_END_ADDR   = MBOX0_START_ADDR + MBOX_SIZE_BYTES - 1;
    localparam logic [ADDR_WIDTH-1:0] MBOX1_START_ADDR = 32'h0009_0000;
    localparam logic [ADDR_WIDTH-1:0] MBOX1_END_ADDR   = MBOX1_START_ADDR + MBOX_SIZE_BYTES - 1;

    // MCU SRAM base, size set per instance
    localparam logic [ADDR_WIDTH-1:0] MCU_SRAM_START_ADDR = 32'h0020_0000;
    localparam int MCU_SRAM_SIZE_KB_DEF = 4;

    //////////////////////////////////////////////////
    // Mailbox valid users
    //////////////////////////////////////////////////
    localparam int NUM_VALID_USERS = 5;
    // Always accepted by both mailboxes
    localparam logic [USER_WIDTH-1:0] MCI_DEF_MBOX_VALID_AXI_USER = 32'hFFFF_FFFF;

    // One valid-user list per mailbox
    typedef logic [NUM_VALID_USERS-1:0][USER_WIDTH-1:0] mbox_users_t;

    //////////////////////////////////////////////////
    // Request and response
    //////////////////////////////////////////////////
    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] wdata;
        logic [STRB_WIDTH-1:0] wstrb;
        logic                  write;
        logic [USER_WIDTH-1:0] user;
    } cif_req_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] rdata;
        // Target needs another cycle
        logic                  hold;
        logic                  error;
    } cif_resp_t;

    // Register block offsets
    typedef enum logic [MCI_REG_MIN_ADDR_WIDTH-1:0] {
        MBOX0_USER0 = 8'h00,
        MBOX0_USER1 = 8'h04,
        MBOX0_USER2 = 8'h08,
        MBOX0_USER3 = 8'h0C,
        MBOX0_USER4 = 8'h10,
        MBOX1_USER0 = 8'h20,
        MBOX1_USER1 = 8'h24,
        MBOX1_USER2 = 8'h28,
        MBOX1_USER3 = 8'h2C,
        MBOX1_USER4 = 8'h30,
        SCRATCH     = 8'h40
    } mci_reg_off_e;

endpackage

/* source/mci_axi_sub_decode.sv */
// MCI subordinate decoder that routes SoC requests to registers, SRAM and mailboxes
`timescale 1ns/100ps

module mci_axi_sub_decode
    import mci_pkg::*;
#(
    parameter int MCU_SRAM_SIZE_KB = MCU_SRAM_SIZE_KB_DEF
) (
    // SoC side
    input  logic                  soc_dv,
    input  cif_req_t              soc_req,
    output cif_resp_t             soc_resp,
    // Valid users from register block
    input  mbox_users_t           valid_mbox0_users,
    input  mbox_users_t           valid_mbox1_users,
    // Privileged user straps
    input  logic [USER_WIDTH-1:0] strap_mcu_lsu_axi_user,
    input  logic [USER_WIDTH-1:0] strap_mcu_ifu_axi_user,
    input  logic [USER_WIDTH-1:0] strap_cptra_axi_user,
    input  logic [USER_WIDTH-1:0] strap_debug_axi_user,
    // Targets
    output logic                  sram_dv,
    output cif_req_t              sram_req,
    input  cif_resp_t             sram_resp,
    output logic                  reg_dv,
    output cif_req_t              reg_req,
    input  cif_resp_t             reg_resp,
    output logic                  mbox0_dv,
    output cif_req_t              mbox0_req,
    input  cif_resp_t             mbox0_resp,
    output logic                  mbox1_dv,
    output cif_req_t              mbox1_req,
    input  cif_resp_t             mbox1_resp,
    // Privileged request flags
    output logic                  mcu_lsu_req,
    output logic                  mcu_ifu_req,
    output logic                  mcu_req,
    output logic                  debug_req,
    output logic                  cptra_req
);

    localparam logic [ADDR_WIDTH-1:0] MCU_SRAM_END_ADDR =
        MCU_SRAM_START_ADDR + MCU_SRAM_SIZE_KB * KB - 1;

    logic all_strb_set;
    logic mbox0_valid_user;
    logic mbox1_valid_user;
    logic sram_sel;
    logic reg_sel;
    logic mbox0_sel;
    logic mbox1_sel;
    logic soc_req_miss;

    // User matches one of the listed entries
    function automatic logic user_listed(mbox_users_t users, logic [USER_WIDTH-1:0] user);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < NUM_VALID_USERS; i++) begin
            hit |= (user == users[i]);
        end
        return hit;
    endfunction

    //////////////////////////////////////////////////
    // Privileged users
    //////////////////////////////////////////////////
    // Zero debug strap turns debug off
    assign debug_req   = soc_dv & (soc_req.user == strap_debug_axi_user) &
                         (|strap_debug_axi_user);
    assign mcu_lsu_req = soc_dv & (soc_req.user == strap_mcu_lsu_axi_user);
    assign mcu_ifu_req = soc_dv & (soc_req.user == strap_mcu_ifu_axi_user);
    assign mcu_req     = mcu_lsu_req | mcu_ifu_req;
    assign cptra_req   = soc_dv & (soc_req.user == strap_cptra_axi_user);

    //////////////////////////////////////////////////
    // Window decode and qualification
    //////////////////////////////////////////////////
    assign all_strb_set = &soc_req.wstrb;

    // Listed, default, MCU or debug users may enter a mailbox
    assign mbox0_valid_user = user_listed(valid_mbox0_users, soc_req.user) |
                              (soc_req.user == MCI_DEF_MBOX_VALID_AXI_USER) |
                              mcu_req | debug_req;
    assign mbox1_valid_user = user_listed(valid_mbox1_users, soc_req.user) |
                              (soc_req.user == MCI_DEF_MBOX_VALID_AXI_USER) |
                              mcu_req | debug_req;

    // SRAM takes partial strobes
    assign sram_sel  = soc_dv &
                       (soc_req.addr inside {[MCU_SRAM_START_ADDR:MCU_SRAM_END_ADDR]});
    assign reg_sel   = soc_dv & all_strb_set &
                       (soc_req.addr inside {[MCI_REG_START_ADDR:MCI_REG_END_ADDR]});
    assign mbox0_sel = soc_dv & all_strb_set & mbox0_valid_user &
                       (soc_req.addr inside {[MBOX0_START_ADDR:MBOX0_END_ADDR]});
    assign mbox1_sel = soc_dv & all_strb_set & mbox1_valid_user &
                       (soc_req.addr inside {[MBOX1_START_ADDR:MBOX1_END_ADDR]});

    // Per-target strobes, request copied to all
    assign sram_dv   = sram_sel;
    assign reg_dv    = reg_sel;
    assign mbox0_dv  = mbox0_sel;
    assign mbox1_dv  = mbox1_sel;
    assign sram_req  = soc_req;
    assign reg_req   = soc_req;
    assign mbox0_req = soc_req;
    assign mbox1_req = soc_req;

    //////////////////////////////////////////////////
    // Response merge
    //////////////////////////////////////////////////
    // Nothing qualified
    assign soc_req_miss = soc_dv & ~(sram_sel | reg_sel | mbox0_sel | mbox1_sel);

    always_comb begin
        soc_resp = '0;
        if (sram_sel) begin
            soc_resp = sram_resp;
        end else if (reg_sel) begin
            soc_resp = reg_resp;
        end else if (mbox0_sel) begin
            soc_resp = mbox0_resp;
        end else if (mbox1_sel) begin
            soc_resp = mbox1_resp;
        end else begin
            // Miss gives zero data, no hold
            soc_resp.error = soc_req_miss;
        end
    end

endmodule

/* source/mci_reg.sv */
// MCI control registers with mailbox valid-user lists and a scratch word
`timescale 1ns/100ps

module mci_reg
    import mci_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  logic        dv,
    input  cif_req_t    req,
    // Write qualifier from decoder
    input  logic        mcu_req,
    output cif_resp_t   resp,
    output mbox_users_t valid_mbox0_users,
    output mbox_users_t valid_mbox1_users
);

    mci_reg_off_e                         reg_off;
    logic [$clog2(NUM_VALID_USERS)-1:0]   user_idx;
    logic                                 wr_en;
    logic [DATA_WIDTH-1:0]                scratch_q;

    // Offset inside register window
    assign reg_off  = mci_reg_off_e'(req.addr[MCI_REG_MIN_ADDR_WIDTH-1:0]);
    // Word index within a user list
    assign user_idx = req.addr[2 +: $clog2(NUM_VALID_USERS)];
    // Only MCU may write
    assign wr_en    = dv & req.write & mcu_req;

    //////////////////////////////////////////////////
    // Register write
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_mbox0_users <= '0;
            valid_mbox1_users <= '0;
            scratch_q         <= '0;
        end else if (wr_en) begin
            case (reg_off)
                MBOX0_USER0, MBOX0_USER1, MBOX0_USER2, MBOX0_USER3, MBOX0_USER4: begin
                    valid_mbox0_users[user_idx] <= req.wdata;
                end
                MBOX1_USER0, MBOX1_USER1, MBOX1_USER2, MBOX1_USER3, MBOX1_USER4: begin
                    valid_mbox1_users[user_idx] <= req.wdata;
                end
                SCRATCH: begin
                    scratch_q <= req.wdata;
                end
                // Unmapped writes dropped
                default: ;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Read and response
    //////////////////////////////////////////////////
    always_comb begin
        resp.rdata = '0;
        // Single cycle, never holds
        resp.hold  = 1'b0;
        // Non-MCU write completes with error
        resp.error = dv & req.write & ~mcu_req;
        case (reg_off)
            MBOX0_USER0, MBOX0_USER1, MBOX0_USER2, MBOX0_USER3, MBOX0_USER4: begin
                resp.rdata = valid_mbox0_users[user_idx];
            end
            MBOX1_USER0, MBOX1_USER1, MBOX1_USER2, MBOX1_USER3, MBOX1_USER4: begin
                resp.rdata = valid_mbox1_users[user_idx];
            end
            SCRATCH: begin
                resp.rdata = scratch_q;
            end
            // Unmapped reads give zero
            default: ;
        endcase
    end

endmodule

/* mbox/mci_mbox.sv */
// Mailbox data memory, 1 KB, whole-word writes and one wait-state reads
`timescale 1ns/100ps

module mci_mbox
    import mci_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      dv,
    input  cif_req_t  req,
    output cif_resp_t resp
);

    localparam int MBOX_DEPTH = MBOX_SIZE_BYTES / STRB_WIDTH;
    localparam int MBOX_AW    = $clog2(MBOX_DEPTH);

    logic [DATA_WIDTH-1:0] mem [MBOX_DEPTH];
    logic [MBOX_AW-1:0]    word_idx;
    logic [DATA_WIDTH-1:0] rdata_q;
    logic                  rd_pending;
    logic                  rd_start;
    logic                  rd_done;
    logic                  wr_en;

    // Word address inside mailbox window
    assign word_idx = req.addr[$clog2(STRB_WIDTH) +: MBOX_AW];
    assign wr_en    = dv & req.write;
    // First read cycle, then completion
    assign rd_start = dv & ~req.write & ~rd_pending;
    assign rd_done  = dv & ~req.write & rd_pending;

    //////////////////////////////////////////////////
    // Storage
    //////////////////////////////////////////////////
    // Decoder guarantees full strobes
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[word_idx] <= req.wdata;
        end
        if (rd_start) begin
            rdata_q <= mem[word_idx];
        end
    end

    // Wait-state tracking
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_pending <= 1'b0;
        end else if (rd_start) begin
            rd_pending <= 1'b1;
        end else if (rd_done) begin
            rd_pending <= 1'b0;
        end
    end

    assign resp.rdata = rdata_q;
    assign resp.hold  = rd_start;
    assign resp.error = 1'b0;

endmodule

/* source/mci_sram.sv */
// MCU SRAM with byte-strobe writes and one wait-state reads
`timescale 1ns/100ps

module mci_sram
    import mci_pkg::*;
#(
    parameter int MCU_SRAM_SIZE_KB = MCU_SRAM_SIZE_KB_DEF
) (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      dv,
    input  cif_req_t  req,
    output cif_resp_t resp
);

    localparam int SRAM_DEPTH = MCU_SRAM_SIZE_KB * KB / STRB_WIDTH;
    localparam int SRAM_AW    = $clog2(SRAM_DEPTH);

    logic [DATA_WIDTH-1:0] mem [SRAM_DEPTH];
    logic [SRAM_AW-1:0]    word_idx;
    logic [DATA_WIDTH-1:0] rdata_q;
    logic                  rd_pending;
    logic                  rd_start;
    logic                  rd_done;
    logic                  wr_en;

    // Word address inside SRAM window
    assign word_idx = req.addr[$clog2(STRB_WIDTH) +: SRAM_AW];
    assign wr_en    = dv & req.write;
    assign rd_start = dv & ~req.write & ~rd_pending;
    assign rd_done  = dv & ~req.write & rd_pending;

    //////////////////////////////////////////////////
    // Storage
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        // Byte lanes gated by strobe
        for (int b = 0; b < STRB_WIDTH; b++) begin
            if (wr_en && req.wstrb[b]) begin
                mem[word_idx][8*b +: 8] <= req.wdata[8*b +: 8];
            end
        end
        if (rd_start) begin
            rdata_q <= mem[word_idx];
        end
    end

    // Wait-state tracking
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_pending <= 1'b0;
        end else if (rd_start) begin
            rd_pending <= 1'b1;
        end else if (rd_done) begin
            rd_pending <= 1'b0;
        end
    end

    assign resp.rdata = rdata_q;
    assign resp.hold  = rd_start;
    assign resp.error = 1'b0;

endmodule

/* source/mci_top.sv */
// MCI top joining the subordinate decoder to registers, SRAM and two mailboxes
`timescale 1ns/100ps

module mci_top
    import mci_pkg::*;
#(
    parameter int MCU_SRAM_SIZE_KB = MCU_SRAM_SIZE_KB_DEF
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  soc_dv,
    input  cif_req_t              soc_req,
    output cif_resp_t             soc_resp,
    input  logic [USER_WIDTH-1:0] strap_mcu_lsu_axi_user,
    input  logic [USER_WIDTH-1:0] strap_mcu_ifu_axi_user,
    input  logic [USER_WIDTH-1:0] strap_cptra_axi_user,
    input  logic [USER_WIDTH-1:0] strap_debug_axi_user,
    output logic                  mcu_lsu_req,
    output logic                  mcu_ifu_req,
    output logic                  mcu_req,
    output logic                  debug_req,
    output logic                  cptra_req
);

    // Decoder to target links
    logic        sram_dv;
    logic        reg_dv;
    logic        mbox0_dv;
    logic        mbox1_dv;
    cif_req_t    sram_req;
    cif_req_t    reg_req;
    cif_req_t    mbox0_req;
    cif_req_t    mbox1_req;
    cif_resp_t   sram_resp;
    cif_resp_t   reg_resp;
    cif_resp_t   mbox0_resp;
    cif_resp_t   mbox1_resp;
    // Valid-user lists
    mbox_users_t valid_mbox0_users;
    mbox_users_t valid_mbox1_users;

    //////////////////////////////////////////////////
    // Decode
    //////////////////////////////////////////////////
    mci_axi_sub_decode #(
        .MCU_SRAM_SIZE_KB (MCU_SRAM_SIZE_KB)
    ) u_decode (
        .soc_dv                 (soc_dv),
        .soc_req                (soc_req),
        .soc_resp               (soc_resp),
        .valid_mbox0_users      (valid_mbox0_users),
        .valid_mbox1_users      (valid_mbox1_users),
        .strap_mcu_lsu_axi_user (strap_mcu_lsu_axi_user),
        .strap_mcu_ifu_axi_user (strap_mcu_ifu_axi_user),
        .strap_cptra_axi_user   (strap_cptra_axi_user),
        .strap_debug_axi_user   (strap_debug_axi_user),
        .sram_dv                (sram_dv),
        .sram_req               (sram_req),
        .sram_resp              (sram_resp),
        .reg_dv                 (reg_dv),
        .reg_req                (reg_req),
        .reg_resp               (reg_resp),
        .mbox0_dv               (mbox0_dv),
        .mbox0_req              (mbox0_req),
        .mbox0_resp             (mbox0_resp),
        .mbox1_dv               (mbox1_dv),
        .mbox1_req              (mbox1_req),
        .mbox1_resp             (mbox1_resp),
        .mcu_lsu_req            (mcu_lsu_req),
        .mcu_ifu_req            (mcu_ifu_req),
        .mcu_req                (mcu_req),
        .debug_req              (debug_req),
        .cptra_req              (cptra_req)
    );

    //////////////////////////////////////////////////
    // Targets
    //////////////////////////////////////////////////
    mci_reg u_reg (
        .clk               (clk),
        .arst_n            (arst_n),
        .dv                (reg_dv),
        .req               (reg_req),
        .mcu_req           (mcu_req),
        .resp              (reg_resp),
        .valid_mbox0_users (valid_mbox0_users),
        .valid_mbox1_users (valid_mbox1_users)
    );

    mci_sram #(
        .MCU_SRAM_SIZE_KB (MCU_SRAM_SIZE_KB)
    ) u_sram (
        .clk    (clk),
        .arst_n (arst_n),
        .dv     (sram_dv),
        .req    (sram_req),
        .resp   (sram_resp)
    );

    mci_mbox u_mbox0 (
        .clk    (clk),
        .arst_n (arst_n),
        .dv     (mbox0_dv),
        .req    (mbox0_req),
        .resp   (mbox0_resp)
    );

    mci_mbox u_mbox1 (
        .clk    (clk),
        .arst_n (arst_n),
        .dv     (mbox1_dv),
        .req    (mbox1_req),
        .resp   (mbox1_resp)
    );

endmodule

/* test/mci_checker.sv */
// MCI checker that watches the top-level ports and compares each completed access
`timescale 1ns/100ps

module mci_checker
    import mci_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,
    // Watched DUT ports
    input  logic                  soc_dv,
    input  cif_req_t              soc_req,
    input  cif_resp_t             soc_resp,
    // Order is lsu, ifu, mcu, debug, cptra
    input  logic [4:0]            flags,
    // Expected values of the access in flight
    input  logic [DATA_WIDTH-1:0] exp_rdata,
    input  logic                  exp_error,
    input  logic                  exp_hold,
    input  logic [4:0]            exp_flags,
    output int                    err_count,
    output int                    done_count
);

    int errs = 0;
    int done = 0;
    // Hold cycles seen in the current access
    int hold_cnt = 0;
    int exp_hold_cnt;

    assign err_count  = errs;
    assign done_count = done;

    //////////////////////////////////////////////////
    // Compare at the falling edge, all levels settled
    //////////////////////////////////////////////////
    always @(negedge clk) begin
        if (arst_n && !soc_dv) begin
            // Idle bus, no privileged flag
            if (flags != 5'h00) begin
                $display("MISMATCH priv_flags idle got 0x%02h expected 0x00", flags);
                errs++;
            end
        end else if (arst_n) begin
            if (flags != exp_flags) begin
                $display("MISMATCH priv_flags addr 0x%08h got 0x%02h expected 0x%02h",
                         soc_req.addr, flags, exp_flags);
                errs++;
            end
            if (soc_resp.hold) begin
                hold_cnt++;
            end else begin
                // Completion cycle
                exp_hold_cnt = exp_hold ? 1 : 0;
                if (soc_resp.error != exp_error) begin
                    $display("MISMATCH soc_resp.error addr 0x%08h got 0x%0h expected 0x%0h",
                             soc_req.addr, soc_resp.error, exp_error);
                    errs++;
                end
                // Read data only matters on reads
                if (!soc_req.write && soc_resp.rdata != exp_rdata) begin
                    $display("MISMATCH soc_resp.rdata addr 0x%08h got 0x%08h expected 0x%08h",
                             soc_req.addr, soc_resp.rdata, exp_rdata);
                    errs++;
                end
                if (hold_cnt != exp_hold_cnt) begin
                    $display("Access at 0x%08h waited %0d hold cycles where %0d were due",
                             soc_req.addr, hold_cnt, exp_hold_cnt);
                    errs++;
                end
                hold_cnt = 0;
                done++;
            end
        end
    end

endmodule

/* test/mci_tb.sv */
// MCI testbench driving decode, qualification, wait states and privileged flags
`timescale 1ns/100ps

module mci_tb
    import mci_pkg::*;
();

    localparam int RESET_CYCLES    = 16;
    localparam int WATCHDOG_CYCLES = 200;
    localparam int SRAM_WORDS      = MCU_SRAM_SIZE_KB_DEF * KB / 4;
    localparam int SRAM_IW         = $clog2(SRAM_WORDS);
    localparam logic [31:0] SRAM_BYTES = 32'(MCU_SRAM_SIZE_KB_DEF * KB);
    // Strap users and an unprivileged one
    localparam logic [31:0] LSU_USER   = 32'h1000_0001;
    localparam logic [31:0] IFU_USER   = 32'h1000_0002;
    localparam logic [31:0] CPTRA_USER = 32'h2000_0003;
    localparam logic [31:0] DEBUG_USER = 32'h3000_0004;
    localparam logic [31:0] GUEST_USER = 32'h5A5A_0005;

    // Expected completion of one access
    typedef struct packed {
        logic [31:0] rdata;
        logic        error;
        logic        hold;
        logic [4:0]  flags;
    } expect_t;

    logic        clk;
    logic        arst_n;
    logic        soc_dv;
    cif_req_t    soc_req;
    cif_resp_t   soc_resp;
    logic [31:0] debug_strap;
    logic        mcu_lsu_req;
    logic        mcu_ifu_req;
    logic        mcu_req;
    logic        debug_req;
    logic        cptra_req;
    logic [31:0] exp_rdata;
    logic        exp_error;
    logic        exp_hold;
    logic [4:0]  exp_flags;
    int          chk_errors;
    int          chk_done;

    // Shadow of the memory map
    logic [31:0] reg_model [64];
    logic [31:0] sram_model [SRAM_WORDS];
    logic [31:0] mbox_model [2][256];

    int           seed = 5497;
    int           issued = 0;
    int           cycle_cnt = 0;
    int           test_num = 0;
    int           tests_ok = 0;
    int           tests_bad = 0;
    int           errs_before = 0;
    mci_reg_off_e off;
    logic [31:0]  addr;
    logic [31:0]  data;
    logic [31:0]  rnd;
    logic [31:0]  user_list [5];

    always #5 clk = ~clk;

    mci_top u_dut (
        .clk                    (clk),
        .arst_n                 (arst_n),
        .soc_dv                 (soc_dv),
        .soc_req                (soc_req),
        .soc_resp               (soc_resp),
        .strap_mcu_lsu_axi_user (LSU_USER),
        .strap_mcu_ifu_axi_user (IFU_USER),
        .strap_cptra_axi_user   (CPTRA_USER),
        .strap_debug_axi_user   (debug_strap),
        .mcu_lsu_req            (mcu_lsu_req),
        .mcu_ifu_req            (mcu_ifu_req),
        .mcu_req                (mcu_req),
        .debug_req              (debug_req),
        .cptra_req              (cptra_req)
    );

    mci_checker u_checker (
        .clk        (clk),
        .arst_n     (arst_n),
        .soc_dv     (soc_dv),
        .soc_req    (soc_req),
        .soc_resp   (soc_resp),
        .flags      ({mcu_lsu_req, mcu_ifu_req, mcu_req, debug_req, cptra_req}),
        .exp_rdata  (exp_rdata),
        .exp_error  (exp_error),
        .exp_hold   (exp_hold),
        .exp_flags  (exp_flags),
        .err_count  (chk_errors),
        .done_count (chk_done)
    );

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////
    // Aligned offsets that hold a register
    function automatic logic reg_mapped(input logic [7:0] roff);
        return (roff[1:0] == 2'b00) &&
               (roff <= 8'h10 || (roff >= 8'h20 && roff <= 8'h30) || roff == 8'h40);
    endfunction

    function automatic logic user_listed(input logic sel, input logic [31:0] user);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < NUM_VALID_USERS; i++) begin
            // Mailbox 1 list starts at word 8
            hit |= (reg_model[{2'b00, sel, 3'(i)}] == user);
        end
        return hit;
    endfunction

    // Expected response and shadow update for accepted writes
    function automatic expect_t predict(input logic wr, input logic [31:0] a,
                                        input logic [31:0] wdata, input logic [3:0] strb,
                                        input logic [31:0] user);
        expect_t              e;
        logic                 full;
        logic                 mcu;
        logic                 dbg;
        logic                 in_mb0;
        logic                 in_mb1;
        logic [SRAM_IW-1:0]   sidx;
        e      = '0;
        full   = (strb == 4'hF);
        mcu    = (user == LSU_USER) || (user == IFU_USER);
        dbg    = (user == debug_strap) && (debug_strap != 32'h0);
        e.flags = {user == LSU_USER, user == IFU_USER, mcu, dbg, user == CPTRA_USER};
        in_mb0 = (a >= MBOX0_START_ADDR) && (a < MBOX0_START_ADDR + 32'h400);
        in_mb1 = (a >= MBOX1_START_ADDR) && (a < MBOX1_START_ADDR + 32'h400);
        if (a < 32'h100 && full) begin
            if (wr) begin
                e.error = !mcu;
                if (mcu && reg_mapped(a[7:0])) begin
                    reg_model[a[7:2]] = wdata;
                end
            end else if (reg_mapped(a[7:0])) begin
                e.rdata = reg_model[a[7:2]];
            end
        end else if (a >= MCU_SRAM_START_ADDR && a < MCU_SRAM_START_ADDR + SRAM_BYTES) begin
            sidx = a[2 +: SRAM_IW];
            if (wr) begin
                // Byte merge under strobe
                for (int b = 0; b < 4; b++) begin
                    if (strb[b]) begin
                        sram_model[sidx][8*b +: 8] = wdata[8*b +: 8];
                    end
                end
            end else begin
                e.rdata = sram_model[sidx];
                e.hold  = 1'b1;
            end
        end else if ((in_mb0 || in_mb1) && full &&
                     (user_listed(in_mb1, user) || user == MCI_DEF_MBOX_VALID_AXI_USER ||
                      mcu || dbg)) begin
            if (wr) begin
                mbox_model[in_mb1][a[9:2]] = wdata;
            end else begin
                e.rdata = mbox_model[in_mb1][a[9:2]];
                e.hold  = 1'b1;
            end
        end else begin
            // Missed every qualified target
            e.error = 1'b1;
        end
        return e;
    endfunction

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////
    task automatic access(input logic wr, input logic [31:0] a, input logic [31:0] wdata,
                          input logic [3:0] strb, input logic [31:0] user);
        expect_t  e;
        cif_req_t r;
        e       = predict(wr, a, wdata, strb, user);
        r.addr  = a;
        r.wdata = wdata;
        r.wstrb = strb;
        r.write = wr;
        r.user  = user;
        @(posedge clk);
        issued++;
        soc_dv    <= 1'b1;
        soc_req   <= r;
        exp_rdata <= e.rdata;
        exp_error <= e.error;
        exp_hold  <= e.hold;
        exp_flags <= e.flags;
        // Completion is the first cycle without hold
        @(negedge clk);
        while (soc_resp.hold) begin
            @(negedge clk);
        end
        @(posedge clk);
        soc_dv <= 1'b0;
    endtask

    task automatic set_debug_strap(input logic [31:0] value);
        @(posedge clk);
        debug_strap <= value;
        @(negedge clk);
    endtask

    task automatic end_test(input string name);
        int errs;
        errs = chk_errors - errs_before;
        test_num++;
        if (errs == 0) begin
            tests_ok++;
        end else begin
            tests_bad++;
        end
        $display("test %0d %s %s (%0d errors)", test_num, name,
                 (errs == 0) ? "ok" : "has errors", errs);
        errs_before = chk_errors;
    endtask

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////
    initial begin
        clk         = 1'b0;
        arst_n      <= 1'b0;
        soc_dv      <= 1'b0;
        soc_req     <= '0;
        debug_strap <= 32'h0;
        exp_rdata   <= '0;
        exp_error   <= 1'b0;
        exp_hold    <= 1'b0;
        exp_flags   <= '0;
        for (int i = 0; i < 64; i++) begin
            reg_model[i] = '0;
        end
        user_list = '{LSU_USER, IFU_USER, CPTRA_USER, DEBUG_USER, GUEST_USER};
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);

        // MCU writes stick while guest writes bounce
        off = off.first();
        repeat (off.num()) begin
            addr = {24'h0, off};
            data = $random(seed);
            access(1'b1, addr, data, 4'hF, LSU_USER);
            access(1'b0, addr, 32'h0, 4'hF, GUEST_USER);
            access(1'b1, addr, ~data, 4'hF, GUEST_USER);
            access(1'b0, addr, 32'h0, 4'hF, GUEST_USER);
            off = off.next();
        end
        end_test("register access");

        // Full write then strobed overwrite then read back
        for (int i = 0; i < 8; i++) begin
            rnd  = $random(seed);
            addr = MCU_SRAM_START_ADDR + {20'h0, rnd[9:0], 2'b00};
            access(1'b1, addr, $random(seed), 4'hF, CPTRA_USER);
            rnd = $random(seed);
            access(1'b1, addr, $random(seed), rnd[3:0], CPTRA_USER);
            access(1'b0, addr, 32'h0, 4'hF, CPTRA_USER);
        end
        end_test("sram strobes");

        for (int mb = 0; mb < 2; mb++) begin
            addr = ((mb == 1) ? MBOX1_START_ADDR : MBOX0_START_ADDR) + 32'h10;
            access(1'b1, addr, $random(seed), 4'hF, GUEST_USER);
            access(1'b0, addr, 32'h0, 4'hF, GUEST_USER);
            // Guest joins this mailbox list as USER2
            access(1'b1, (mb == 1) ? 32'h28 : 32'h08, GUEST_USER, 4'hF, LSU_USER);
            access(1'b1, addr, $random(seed), 4'hF, GUEST_USER);
            access(1'b0, addr, 32'h0, 4'hF, GUEST_USER);
            access(1'b1, addr + 32'h4, $random(seed), 4'hF, MCI_DEF_MBOX_VALID_AXI_USER);
            access(1'b0, addr + 32'h4, 32'h0, 4'hF, MCI_DEF_MBOX_VALID_AXI_USER);
            access(1'b1, addr + 32'h8, $random(seed), 4'hF, IFU_USER);
            access(1'b0, addr + 32'h8, 32'h0, 4'hF, IFU_USER);
        end
        end_test("mailbox users");

        // Partial strobes and holes in the map
        access(1'b1, 32'h40, $random(seed), 4'h3, LSU_USER);
        access(1'b0, 32'h40, 32'h0, 4'hF, LSU_USER);
        access(1'b1, MBOX0_START_ADDR, $random(seed), 4'h7, MCI_DEF_MBOX_VALID_AXI_USER);
        access(1'b0, 32'h0010_0000, 32'h0, 4'hF, LSU_USER);
        access(1'b0, MCU_SRAM_START_ADDR + SRAM_BYTES, 32'h0, 4'hF, LSU_USER);
        end_test("misses");

        // Debug strap still zero here
        foreach (user_list[i]) begin
            access(1'b0, 32'h40, 32'h0, 4'hF, user_list[i]);
        end
        access(1'b0, MBOX1_START_ADDR + 32'h20, 32'h0, 4'hF, DEBUG_USER);
        // User zero equals the zero strap but is no debug user
        access(1'b0, 32'h40, 32'h0, 4'hF, 32'h0);
        access(1'b0, MBOX1_START_ADDR + 32'h20, 32'h0, 4'hF, 32'h0);
        set_debug_strap(DEBUG_USER);
        access(1'b0, 32'h40, 32'h0, 4'hF, DEBUG_USER);
        access(1'b1, MBOX1_START_ADDR + 32'h20, $random(seed), 4'hF, DEBUG_USER);
        access(1'b0, MBOX1_START_ADDR + 32'h20, 32'h0, 4'hF, DEBUG_USER);
        end_test("privileged flags");

        @(posedge clk);
        if (chk_done != issued) begin
            $display("Checker saw %0d completed accesses but %0d were issued", chk_done, issued);
        end
        $display("summary: %0d tests ok, %0d tests with errors, %0d errors in %0d accesses",
                 tests_ok, tests_bad, chk_errors, chk_done);
        if (tests_bad == 0 && chk_errors == 0 && chk_done == issued) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    //////////////////////////////////////////////////
    // Watchdog
    //////////////////////////////////////////////////
    // Budget grows with every issued access
    initial begin
        while (cycle_cnt < RESET_CYCLES + WATCHDOG_CYCLES * (issued + 1)) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Watchdog expired after %0d cycles, DUT hung with %0d accesses issued",
                 cycle_cnt, issued);
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* filelist.f */
common/mci_pkg.sv
source/mci_axi_sub_decode.sv
source/mci_reg.sv
mbox/mci_mbox.sv
source/mci_sram.sv
source/mci_top.sv
test/mci_checker.sv
test/mci_tb.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
verilator --binary --timing --timescale 1ns/100ps --top-module mci_tb \
    -f filelist.f -o mci_sim \
    && ./obj_dir/mci_sim | tee /dev/stderr | grep -q "TEST PASSED" \
    || { echo "simulation did not pass"; exit 1; }
